// ==== design/lifo_pkg.sv ====
// stack defaults and operation strobe layout
// referenced by scoped name from the stack, the top level and the bench
package lifo_pkg;

    // default geometry, the top level passes these down as parameters
    localparam int WIDTH_DEF = 16;     // bits per entry
    localparam int DEPTH_DEF = 8;      // entries, two at least for s0 and s1

    // operation strobe vector, one bit per strobe
    localparam int OP_W    = 3;
    localparam int OP_PUSH = 0;        // shift down, load data on top
    localparam int OP_POP  = 1;        // shift up, zero at the bottom
    localparam int OP_SWAP = 2;        // exchange s0 and s1

    // push and pop together replace the top entry
    // swap is honoured only with push and pop both low

endpackage

// ==== design/bist_pkg.sv ====
// layout of one self-test script step and the reserved step numbers
// shared by the script ROM and the self-test sequencer
package bist_pkg;

    localparam int STEP_W      = 5;    // step index width
    localparam int DATA_W      = 16;   // data and expected value fields
    localparam int STEP_WORD_W = 58;   // whole step word

    // reserved steps
    localparam logic [STEP_W-1:0] ST_STOP  = 5'd0;     // run ended or idle
    localparam logic [STEP_W-1:0] ST_START = 5'd1;     // first step of a run
    localparam logic [STEP_W-1:0] ST_DONE  = 5'd31;    // script completed

    // Field offsets inside a step word, msb first:
    // data, push, pop, swap, s0 compare, s0 expected, s1 compare,
    // s1 expected and the next step number in the low bits.
    localparam int DATA_LSB   = 42;    // data [57:42]
    localparam int PUSH_BIT   = 41;
    localparam int POP_BIT    = 40;
    localparam int SWAP_BIT   = 39;
    localparam int S0_CMP_BIT = 38;
    localparam int S0_EXP_LSB = 22;    // s0 expected [37:22]
    localparam int S1_CMP_BIT = 21;
    localparam int S1_EXP_LSB = 5;     // s1 expected [20:5]
    localparam int NEXT_LSB   = 0;     // next step [4:0]

endpackage

// ==== design/lifo_stack.sv ====
// shift-register operand stack with push, pop, replace and swap
// s0 and s1 are the two top registers and show each result one cycle later
`timescale 1ns/100ps

module lifo_stack #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 8
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  logic             i_pop,
    input  logic             i_swap,
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_s0,     // top of stack
    output logic [WIDTH-1:0] o_s1      // next on stack
);

    logic [lifo_pkg::OP_W-1:0] op;
    logic [WIDTH-1:0]          stk [DEPTH];

    logic do_replace;
    logic do_push;
    logic do_pop;
    logic do_swap;

    // gather the strobes into one operation vector
    always_comb begin
        op                    = '0;
        op[lifo_pkg::OP_PUSH] = i_push;
        op[lifo_pkg::OP_POP]  = i_pop;
        op[lifo_pkg::OP_SWAP] = i_swap;
    end

    // priority decode, swap only when neither push nor pop
    assign do_replace = op[lifo_pkg::OP_PUSH] && op[lifo_pkg::OP_POP];
    assign do_push    = op[lifo_pkg::OP_PUSH] && !op[lifo_pkg::OP_POP];
    assign do_pop     = op[lifo_pkg::OP_POP] && !op[lifo_pkg::OP_PUSH];
    assign do_swap    = op[lifo_pkg::OP_SWAP] && !op[lifo_pkg::OP_PUSH]
                        && !op[lifo_pkg::OP_POP];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stk[i] <= '0;
            end
        end else if (do_replace) begin
            stk[0] <= i_data;                          // only the top changes
        end else if (do_push) begin
            stk[0] <= i_data;
            for (int i = 1; i < DEPTH; i++) begin
                stk[i] <= stk[i-1];                    // bottom entry falls off
            end
        end else if (do_pop) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                stk[i] <= stk[i+1];
            end
            stk[DEPTH-1] <= '0;                        // refill bottom with zero
        end else if (do_swap) begin
            stk[0] <= stk[1];
            stk[1] <= stk[0];
        end
    end

    assign o_s0 = stk[0];
    assign o_s1 = stk[1];

endmodule

// ==== design/lifo_bist_rom.sv ====
// self-test script table, one step word per step number
// purely combinational; unused steps lead to STOP
`timescale 1ns/100ps

module lifo_bist_rom (
    input  logic [bist_pkg::STEP_W-1:0]      i_step,
    output logic [bist_pkg::STEP_WORD_W-1:0] o_word
);

    // operation codes as {push, pop, swap}
    localparam logic [2:0] NOP  = 3'b000;
    localparam logic [2:0] PUSH = 3'b100;
    localparam logic [2:0] POP  = 3'b010;
    localparam logic [2:0] RPL  = 3'b110;  // pop with push
    localparam logic [2:0] SWAP = 3'b001;

    localparam logic [bist_pkg::DATA_W-1:0] NONE = '0;

    function automatic logic [bist_pkg::STEP_WORD_W-1:0] step_word(
        input logic [bist_pkg::DATA_W-1:0] data,
        input logic [2:0]                  ops,
        input logic                        s0_cmp,
        input logic [bist_pkg::DATA_W-1:0] s0_exp,
        input logic                        s1_cmp,
        input logic [bist_pkg::DATA_W-1:0] s1_exp,
        input logic [bist_pkg::STEP_W-1:0] next
    );
        logic [bist_pkg::STEP_WORD_W-1:0] w;
        w                                             = '0;
        w[bist_pkg::DATA_LSB +: bist_pkg::DATA_W]     = data;
        w[bist_pkg::PUSH_BIT]                         = ops[2];
        w[bist_pkg::POP_BIT]                          = ops[1];
        w[bist_pkg::SWAP_BIT]                         = ops[0];
        w[bist_pkg::S0_CMP_BIT]                       = s0_cmp;
        w[bist_pkg::S0_EXP_LSB +: bist_pkg::DATA_W]   = s0_exp;
        w[bist_pkg::S1_CMP_BIT]                       = s1_cmp;
        w[bist_pkg::S1_EXP_LSB +: bist_pkg::DATA_W]   = s1_exp;
        w[bist_pkg::NEXT_LSB +: bist_pkg::STEP_W]     = next;
        return w;
    endfunction

    // a check in a step sees the stack as left by the previous step
    always_comb begin
        case (i_step)
            bist_pkg::ST_START: o_word = step_word(NONE, NOP, 1'b0, NONE, 1'b0, NONE, 5'd2);
            5'd2:  o_word = step_word(16'd13, PUSH, 1'b0, NONE, 1'b0, NONE, 5'd3);
            5'd3:  o_word = step_word(NONE, NOP, 1'b1, 16'd13, 1'b0, NONE, 5'd4);
            5'd4:  o_word = step_word(16'd21, PUSH, 1'b0, NONE, 1'b0, NONE, 5'd5);
            5'd5:  o_word = step_word(NONE, NOP, 1'b1, 16'd21, 1'b1, 16'd13, 5'd6);
            5'd6:  o_word = step_word(NONE, POP, 1'b0, NONE, 1'b0, NONE, 5'd7);
            5'd7:  o_word = step_word(NONE, NOP, 1'b1, 16'd13, 1'b0, NONE, 5'd8);
            5'd8:  o_word = step_word(16'd34, RPL, 1'b0, NONE, 1'b0, NONE, 5'd9);
            5'd9:  o_word = step_word(NONE, NOP, 1'b1, 16'd34, 1'b0, NONE, 5'd10);
            5'd10: o_word = step_word(16'd55, PUSH, 1'b0, NONE, 1'b0, NONE, 5'd11);
            5'd11: o_word = step_word(NONE, NOP, 1'b1, 16'd55, 1'b1, 16'd34, 5'd12);
            5'd12: o_word = step_word(16'd89, PUSH, 1'b0, NONE, 1'b0, NONE, 5'd13);
            // from here every step checks and operates at once
            5'd13: o_word = step_word(NONE, SWAP, 1'b1, 16'd89, 1'b1, 16'd55, 5'd14);
            5'd14: o_word = step_word(NONE, POP, 1'b1, 16'd55, 1'b1, 16'd89, 5'd15);
            5'd15: o_word = step_word(NONE, POP, 1'b1, 16'd89, 1'b1, 16'd34, 5'd16);
            5'd16: o_word = step_word(NONE, NOP, 1'b1, 16'd34, 1'b0, NONE, bist_pkg::ST_DONE);
            bist_pkg::ST_DONE: o_word = step_word(NONE, NOP, 1'b0, NONE, 1'b0, NONE,
                                                  bist_pkg::ST_STOP);
            default: o_word = step_word(NONE, NOP, 1'b0, NONE, 1'b0, NONE,
                                        bist_pkg::ST_STOP);    // STOP loops on itself
        endcase
    end

endmodule

// ==== design/lifo_bist.sv ====
// self-test sequencer, steps through the script ROM and checks s0 and s1
// owns the stack strobes: user operations when idle, script operations when running
`timescale 1ns/100ps

module lifo_bist #(
    parameter int WIDTH = 16
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    // test control
    input  logic                             i_run,
    output logic                             o_running,
    output logic                             o_passed,
    // user operations
    input  logic                             i_usr_push,
    input  logic                             i_usr_pop,
    input  logic                             i_usr_swap,
    input  logic [WIDTH-1:0]                 i_usr_data,
    // stack data
    input  logic [WIDTH-1:0]                 i_s0,
    input  logic [WIDTH-1:0]                 i_s1,
    // script
    input  logic [bist_pkg::STEP_WORD_W-1:0] i_word,
    output logic [bist_pkg::STEP_W-1:0]      o_step,
    // stack operations
    output logic                             o_push,
    output logic                             o_pop,
    output logic                             o_swap,
    output logic [WIDTH-1:0]                 o_data
);

    logic [bist_pkg::STEP_W-1:0] step;
    logic [bist_pkg::STEP_W-1:0] next_step;

    logic             scr_push;
    logic             scr_pop;
    logic             scr_swap;
    logic [WIDTH-1:0] scr_data;
    logic             s0_cmp;
    logic [WIDTH-1:0] s0_exp;
    logic             s1_cmp;
    logic [WIDTH-1:0] s1_exp;
    logic             mismatch;

    // script fields
    assign scr_data  = WIDTH'(i_word[bist_pkg::DATA_LSB +: bist_pkg::DATA_W]);
    assign scr_push  = i_word[bist_pkg::PUSH_BIT];
    assign scr_pop   = i_word[bist_pkg::POP_BIT];
    assign scr_swap  = i_word[bist_pkg::SWAP_BIT];
    assign s0_cmp    = i_word[bist_pkg::S0_CMP_BIT];
    assign s0_exp    = WIDTH'(i_word[bist_pkg::S0_EXP_LSB +: bist_pkg::DATA_W]);
    assign s1_cmp    = i_word[bist_pkg::S1_CMP_BIT];
    assign s1_exp    = WIDTH'(i_word[bist_pkg::S1_EXP_LSB +: bist_pkg::DATA_W]);
    assign next_step = i_word[bist_pkg::NEXT_LSB +: bist_pkg::STEP_W];

    assign mismatch = (s0_cmp && (i_s0 != s0_exp)) || (s1_cmp && (i_s1 != s1_exp));

    assign o_running = i_run && (step != bist_pkg::ST_STOP);
    assign o_step    = step;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            step <= bist_pkg::ST_START;
        end else if (!i_run) begin
            step <= bist_pkg::ST_START;                // rearm for the next run
        end else if (o_running) begin
            step <= mismatch ? bist_pkg::ST_STOP : next_step;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_passed <= 1'b0;
        end else if (o_running) begin
            if (step == bist_pkg::ST_START) begin
                o_passed <= 1'b0;                      // fresh run
            end else if (step == bist_pkg::ST_DONE) begin
                o_passed <= 1'b1;                      // whole script matched
            end
        end
    end

    // user strobes are ignored while the script owns the stack
    assign o_push = o_running ? scr_push : i_usr_push;
    assign o_pop  = o_running ? scr_pop  : i_usr_pop;
    assign o_swap = o_running ? scr_swap : i_usr_swap;
    assign o_data = o_running ? scr_data : i_usr_data;

endmodule

// ==== design/lifo_top.sv ====
// operand stack with its script-driven self-test
// user strobes reach the stack whenever no self-test run is active
`timescale 1ns/100ps

module lifo_top #(
    parameter int WIDTH = lifo_pkg::WIDTH_DEF,
    parameter int DEPTH = lifo_pkg::DEPTH_DEF
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  logic             i_pop,
    input  logic             i_swap,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_run,
    output logic             o_running,
    output logic             o_passed,
    output logic [WIDTH-1:0] o_s0,
    output logic [WIDTH-1:0] o_s1
);

    logic                             stk_push;
    logic                             stk_pop;
    logic                             stk_swap;
    logic [WIDTH-1:0]                 stk_data;
    logic [bist_pkg::STEP_W-1:0]      step;
    logic [bist_pkg::STEP_WORD_W-1:0] step_word;

    // script values are DATA_W wide, the stack must match
    if (WIDTH != bist_pkg::DATA_W) begin : g_width_check
        $error("stack width %0d differs from script data width %0d",
               WIDTH, bist_pkg::DATA_W);
    end

    lifo_stack #(
        .WIDTH (WIDTH),
        .DEPTH (DEPTH)
    ) lifo_stack_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (stk_push),
        .i_pop   (stk_pop),
        .i_swap  (stk_swap),
        .i_data  (stk_data),
        .o_s0    (o_s0),
        .o_s1    (o_s1)
    );

    lifo_bist #(
        .WIDTH (WIDTH)
    ) lifo_bist_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_run      (i_run),
        .o_running  (o_running),
        .o_passed   (o_passed),
        .i_usr_push (i_push),
        .i_usr_pop  (i_pop),
        .i_usr_swap (i_swap),
        .i_usr_data (i_data),
        .i_s0       (o_s0),
        .i_s1       (o_s1),
        .i_word     (step_word),
        .o_step     (step),
        .o_push     (stk_push),
        .o_pop      (stk_pop),
        .o_swap     (stk_swap),
        .o_data     (stk_data)
    );

    lifo_bist_rom lifo_bist_rom_i (
        .i_step (step),
        .o_word (step_word)
    );

endmodule

// ==== bench/lifo_checker.sv ====
// reference model of the operand stack and its self-test sequencer
// sits beside the DUT in the testbench, updates on rising edges and compares on falling edges
`timescale 1ns/100ps

module lifo_checker #(
    parameter int WIDTH = lifo_pkg::WIDTH_DEF,
    parameter int DEPTH = lifo_pkg::DEPTH_DEF
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  logic             i_pop,
    input  logic             i_swap,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_run,
    input  logic             i_running,
    input  logic             i_passed,
    input  logic [WIDTH-1:0] i_s0,
    input  logic [WIDTH-1:0] i_s1,
    output int               o_err_cnt,
    output int               o_chk_cnt
);

    localparam int RUN_CYCLES = 17;     // i_run high to o_running low

    logic [WIDTH-1:0] m_stk [DEPTH];
    logic             m_armed;          // sequencer not yet stopped
    logic             m_passed;
    int               m_cnt;            // cycle inside the current run
    bit               m_valid = 1'b0;   // set once a reset edge was seen
    int               run_len = 0;
    int               err_cnt = 0;
    int               chk_cnt = 0;

    assign o_err_cnt = err_cnt;
    assign o_chk_cnt = chk_cnt;

    // script operations by run cycle as {push, pop, swap, data}
    function automatic logic [WIDTH+2:0] script_op(input int cyc);
        case (cyc)
            1:       return {3'b100, WIDTH'(13)};
            3:       return {3'b100, WIDTH'(21)};
            5:       return {3'b010, WIDTH'(0)};
            7:       return {3'b110, WIDTH'(34)};    // pop with push
            9:       return {3'b100, WIDTH'(55)};
            11:      return {3'b100, WIDTH'(89)};
            12:      return {3'b001, WIDTH'(0)};
            13:      return {3'b010, WIDTH'(0)};
            14:      return {3'b010, WIDTH'(0)};
            default: return '0;                       // check-only cycles
        endcase
    endfunction

    task automatic apply_op(input logic push, input logic pop, input logic swap,
                            input logic [WIDTH-1:0] val);
        logic [WIDTH-1:0] tmp;
        if (push && pop) begin
            m_stk[0] = val;
        end else if (push) begin
            for (int i = DEPTH - 1; i > 0; i--) begin
                m_stk[i] = m_stk[i-1];
            end
            m_stk[0] = val;
        end else if (pop) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                m_stk[i] = m_stk[i+1];
            end
            m_stk[DEPTH-1] = '0;
        end else if (swap) begin
            tmp      = m_stk[0];
            m_stk[0] = m_stk[1];
            m_stk[1] = tmp;
        end
    endtask

    task automatic compare(input string what, input logic [WIDTH-1:0] got,
                           input logic [WIDTH-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s is %0h, model expects %0h",
                     $time, what, got, exp);
        end
    endtask

    always @(posedge i_clk) begin : model_update
        logic [WIDTH+2:0] op;
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                m_stk[i] = '0;
            end
            m_armed  = 1'b1;
            m_cnt    = 0;
            m_passed = 1'b0;
            m_valid  = 1'b1;
        end else if (i_run && m_armed) begin
            op = script_op(m_cnt);                   // user strobes ignored here
            apply_op(op[WIDTH+2], op[WIDTH+1], op[WIDTH], op[WIDTH-1:0]);
            if (m_cnt == 0) begin
                m_passed = 1'b0;
            end
            if (m_cnt == RUN_CYCLES - 1) begin
                m_passed = 1'b1;                     // done step reached
                m_armed  = 1'b0;
            end
            m_cnt++;
        end else begin
            apply_op(i_push, i_pop, i_swap, i_data);
            if (!i_run) begin
                m_armed = 1'b1;                      // rearm for the next run
                m_cnt   = 0;
            end
        end
    end

    always @(negedge i_clk) begin
        if (m_valid) begin
            compare("s0", i_s0, m_stk[0]);
            compare("s1", i_s1, m_stk[1]);
            compare("running", WIDTH'(i_running), WIDTH'(i_run && m_armed));
            compare("passed", WIDTH'(i_passed), WIDTH'(m_passed));
            if (i_running === 1'b1) begin
                run_len++;
            end else begin
                if (run_len != 0 && i_run) begin
                    compare("run length", WIDTH'(run_len), WIDTH'(RUN_CYCLES));
                end
                run_len = 0;
            end
        end
    end

endmodule

// ==== bench/tb_lifo_top.sv ====
// testbench for the operand stack with self-test: random user traffic and self-test runs
// lifo_checker does the comparing, this module drives stimulus and prints the verdict
`timescale 1ns/100ps

module tb_lifo_top;

    localparam int WIDTH       = lifo_pkg::WIDTH_DEF;
    localparam int DEPTH       = lifo_pkg::DEPTH_DEF;
    localparam int SEED        = 62048;
    localparam int RUN_TIMEOUT = 50;    // cycles allowed for one run

    logic             clk;
    logic             rst_n;
    logic             push;
    logic             pop;
    logic             swap;
    logic [WIDTH-1:0] data;
    logic             run;
    logic             running;
    logic             passed;
    logic [WIDTH-1:0] s0;
    logic [WIDTH-1:0] s1;
    int               err_cnt;
    int               chk_cnt;
    int               timeouts;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;              // 4 ns period
        end
    end

    lifo_top #(
        .WIDTH (WIDTH),
        .DEPTH (DEPTH)
    ) lifo_top_i (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_push    (push),
        .i_pop     (pop),
        .i_swap    (swap),
        .i_data    (data),
        .i_run     (run),
        .o_running (running),
        .o_passed  (passed),
        .o_s0      (s0),
        .o_s1      (s1)
    );

    lifo_checker #(
        .WIDTH (WIDTH),
        .DEPTH (DEPTH)
    ) lifo_checker_i (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_push    (push),
        .i_pop     (pop),
        .i_swap    (swap),
        .i_data    (data),
        .i_run     (run),
        .i_running (running),
        .i_passed  (passed),
        .i_s0      (s0),
        .i_s1      (s1),
        .o_err_cnt (err_cnt),
        .o_chk_cnt (chk_cnt)
    );

    task automatic drive_op(input logic p, input logic q, input logic s,
                            input logic [WIDTH-1:0] d);
        @(posedge clk);
        push <= p;
        pop  <= q;
        swap <= s;
        data <= d;
    endtask

    task automatic random_op();
        logic [2:0] ops;
        ops = 3'($urandom);
        drive_op(ops[0], ops[1], ops[2], WIDTH'($urandom));
    endtask

    task automatic push_burst(input int n);
        repeat (n) drive_op(1'b1, 1'b0, 1'b0, WIDTH'($urandom));
    endtask

    task automatic pop_burst(input int n);
        repeat (n) drive_op(1'b0, 1'b1, 1'b0, WIDTH'($urandom));
    endtask

    task automatic hold_idle(input int n);
        repeat (n) drive_op(1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic set_run(input logic level);
        @(posedge clk);
        run <= level;
    endtask

    // raise i_run and wait for o_running to fall, optionally with user noise
    task automatic run_selftest(input bit noise);
        int cycles;
        bit done;
        cycles = 0;
        done   = 1'b0;
        set_run(1'b1);
        while (!done && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            if (!running) begin
                done = 1'b1;
            end else begin
                cycles++;
                if (noise) begin
                    random_op();
                end else begin
                    hold_idle(1);
                end
            end
        end
        if (!done) begin
            timeouts++;
            $display("self-test run still active after %0d cycles at %0t", RUN_TIMEOUT, $time);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        push     = 1'b0;
        pop      = 1'b0;
        swap     = 1'b0;
        data     = '0;
        run      = 1'b0;
        timeouts = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        hold_idle(3);                   // reset state is checked here

        repeat (200) random_op();
        push_burst(DEPTH + 3);          // bottom entries fall off
        pop_burst(DEPTH + 3);           // pops past empty
        push_burst(4);
        drive_op(1'b1, 1'b1, 1'b0, WIDTH'($urandom));    // replace
        drive_op(1'b1, 1'b1, 1'b1, WIDTH'($urandom));    // replace, no swap
        drive_op(1'b1, 1'b0, 1'b1, WIDTH'($urandom));    // push, no swap
        drive_op(1'b0, 1'b1, 1'b1, WIDTH'($urandom));    // pop, no swap
        drive_op(1'b0, 1'b0, 1'b1, WIDTH'($urandom));    // plain swap
        repeat (60) random_op();

        run_selftest(1'b1);             // from random contents, strobes ignored
        repeat (30) random_op();        // run still high, user ops pass again
        set_run(1'b0);
        repeat (10) random_op();
        run_selftest(1'b0);
        hold_idle(3);
        set_run(1'b0);
        repeat (20) random_op();
        run_selftest(1'b1);
        hold_idle(4);

        $display("checks: %0d, errors: %0d, timeouts: %0d", chk_cnt, err_cnt, timeouts);
        if (err_cnt == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
design/lifo_pkg.sv
design/bist_pkg.sv
design/lifo_stack.sv
design/lifo_bist_rom.sv
design/lifo_bist.sv
design/lifo_top.sv
bench/lifo_checker.sv
bench/tb_lifo_top.sv

// ==== Bender.yml ====
package:
  name: lifo_stack

sources:
  # design sources, packages first
  - target: any(rtl, test)
    files:
      - design/lifo_pkg.sv
      - design/bist_pkg.sv
      - design/lifo_stack.sv
      - design/lifo_bist_rom.sv
      - design/lifo_bist.sv
      - design/lifo_top.sv

  # testbench, top module tb_lifo_top
  - target: test
    files:
      - bench/lifo_checker.sv
      - bench/tb_lifo_top.sv
